// ==== sim/io_top_input.txt ====
# columns, all hex: we addr wdata strb exp_rdata exp_err back_to_back
# we 1 writes and 0 reads; back_to_back 1 issues on the cycle after the previous access
# full words into all four lanes of RAM line 2
1 40010020 a0a1a2a3 f 00000000 0 0
1 40010024 b0b1b2b3 f 00000000 0 0
1 40010028 c0c1c2c3 f 00000000 0 1
1 4001002c d0d1d2d3 f 00000000 0 0
0 40010020 00000000 0 a0a1a2a3 0 0
0 40010024 00000000 0 b0b1b2b3 0 0
0 40010028 00000000 0 c0c1c2c3 0 0
0 4001002c 00000000 0 d0d1d2d3 0 0
# bytes 0 and 2 of lane 1 only
1 40010024 11223344 5 00000000 0 0
0 40010024 00000000 0 b022b244 0 0
# reads on consecutive cycles across the lanes
0 4001002c 00000000 0 d0d1d2d3 0 0
0 40010020 00000000 0 a0a1a2a3 0 1
0 40010028 00000000 0 c0c1c2c3 0 1
0 40010024 00000000 0 b022b244 0 1
# addresses outside both windows, then RAM again
0 40020000 00000000 0 00000000 1 0
1 40000008 deadbeef f 00000000 1 1
0 40010028 00000000 0 c0c1c2c3 0 1
# last RAM line
1 40010ffc 5a5b5c5d f 00000000 0 0
0 40010ffc 00000000 0 5a5b5c5d 0 0
# host register pair, tohost ends the test with code 15
1 40000004 cafef00d f 00000000 0 0
0 40000004 00000000 0 cafef00d 0 0
1 40000000 0000002b f 00000000 0 0
0 40000000 00000000 0 0000002b 0 1

// ==== project.f ====
hdl/io_pkg.sv
hdl/io_decoder.sv
hdl/bram_lane_ctrl.sv
hdl/bram_array.sv
hdl/host_regs.sv
hdl/io_top.sv
sim/io_top_props.sv
sim/tb_io_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the IO region testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_io_top -Mdir obj_dir -f project.f \
   || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vtb_io_top 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "Done: no errors" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== sim/tb_io_top.sv ====
// testbench for the IO region top, file driven accesses with response checks

`timescale 1ns/1ps

module tb_io_top import io_pkg::*; ();

   localparam int    RAND_SEED    = 38;
   localparam int    RESET_CYCLES = 8;
   localparam int    RSP_TIMEOUT  = 4;        // cycles from request to response
   localparam int    DRAIN_CYCLES = 10;
   localparam int    WATCHDOG_NS  = 200_000;
   localparam string INPUT_FILE   = "sim/io_top_input.txt";

   // one outstanding access and what it should return
   typedef struct packed {
      logic        we;
      logic [31:0] addr;
      logic [31:0] rdata;
      logic        err;
      logic        host_exit;
      logic [30:0] host_code;
      logic [31:0] issue_cycle;
   } exp_t;

   logic        ram_clk;
   logic        arst_n_i;
   logic        req_i;
   logic        we_i;
   io_addr_t    addr_i;
   io_data_t    wdata_i;
   io_strb_t    strb_i;
   logic        rsp_valid_o;
   io_data_t    rdata_o;
   logic        err_o;
   logic        host_exit_o;
   logic [30:0] host_code_o;

   exp_t        exp_q [$];
   logic [31:0] tohost_model;   // what tohost should hold
   logic [31:0] cycle_cnt;
   int          n_checks;
   int          n_errors;

   io_top i_dut (
      .ram_clk     ( ram_clk     ),
      .arst_n_i    ( arst_n_i    ),
      .req_i       ( req_i       ),
      .we_i        ( we_i        ),
      .addr_i      ( addr_i      ),
      .wdata_i     ( wdata_i     ),
      .strb_i      ( strb_i      ),
      .rsp_valid_o ( rsp_valid_o ),
      .rdata_o     ( rdata_o     ),
      .err_o       ( err_o       ),
      .host_exit_o ( host_exit_o ),
      .host_code_o ( host_code_o )
   );

   always #50 ram_clk = ~ram_clk;

   always @(posedge ram_clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   //////////////////////////////////////////////////
   // checks and reporting

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      n_checks++;
      if (got !== expected) begin
         n_errors++;
         $display("ERR %0t ns: %s got %h expected %h", $time, name, got, expected);
      end
   endtask

   task automatic check_response(input exp_t e);
      check_value("err_o", 32'(err_o), 32'(e.err));
      if (!e.we && !e.err) begin
         check_value("rdata_o", rdata_o, e.rdata);
      end
      check_value("host_exit_o", 32'(host_exit_o), 32'(e.host_exit));
      check_value("host_code_o", 32'(host_code_o), 32'(e.host_code));
   endtask

   task automatic close_run();
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   // responses are sampled mid cycle, away from the rising edge
   always @(negedge ram_clk) begin
      exp_t head;
      if (arst_n_i) begin
         if (rsp_valid_o) begin
            if (exp_q.size() == 0) begin
               n_errors++;
               $display("response at %0t ns without an outstanding request", $time);
            end else begin
               head = exp_q.pop_front();
               // response belongs in the cycle right after its request
               check_value("rsp_valid_o delay", cycle_cnt - head.issue_cycle, 32'd1);
               check_response(head);
            end
         end else if (exp_q.size() > 0 && cycle_cnt - exp_q[0].issue_cycle > RSP_TIMEOUT) begin
            head = exp_q.pop_front();
            n_errors++;
            $display("no response within %0d cycles for the access to %h",
                     RSP_TIMEOUT, head.addr);
         end
      end
   end

   //////////////////////////////////////////////////
   // stimulus

   task automatic drive_idle();
      @(negedge ram_clk);
      req_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic drive_access(input logic we, input io_addr_t addr, input io_data_t wdata,
                               input io_strb_t strb, input io_data_t rdata, input logic err);
      exp_t e;
      int   i;
      @(negedge ram_clk);
      req_i   = 1'b1;
      we_i    = we;
      addr_i  = addr;
      wdata_i = wdata;
      strb_i  = strb;
      // tohost sits at the even word of the host window
      if (we && (addr & HOST_MASK) == HOST_BASE && addr[2] == 1'b0) begin
         for (i = 0; i < 4; i++) begin
            if (strb[i]) begin
               tohost_model[i*8 +: 8] = wdata[i*8 +: 8];
            end
         end
      end
      e.we          = we;
      e.addr        = addr;
      e.rdata       = rdata;
      e.err         = err;
      e.host_exit   = tohost_model[0];
      e.host_code   = tohost_model[31:1];
      e.issue_cycle = cycle_cnt;
      exp_q.push_back(e);
   endtask

   initial begin
      int          fd;
      int          n_fields;
      int          gaps;
      int          wait_cycles;
      string       line;
      logic [31:0] f_we;
      logic [31:0] f_addr;
      logic [31:0] f_wdata;
      logic [31:0] f_strb;
      logic [31:0] f_rdata;
      logic [31:0] f_err;
      logic [31:0] f_b2b;

      ram_clk      = 1'b0;
      arst_n_i     = 1'b0;
      req_i        = 1'b0;
      we_i         = 1'b0;
      addr_i       = '0;
      wdata_i      = '0;
      strb_i       = '0;
      tohost_model = '0;
      cycle_cnt    = '0;
      n_checks     = 0;
      n_errors     = 0;
      void'($urandom(RAND_SEED));

      repeat (RESET_CYCLES) @(negedge ram_clk);
      arst_n_i = 1'b1;
      @(negedge ram_clk);
      check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
      check_value("err_o", 32'(err_o), 32'h0);
      check_value("host_exit_o", 32'(host_exit_o), 32'h0);
      check_value("host_code_o", 32'(host_code_o), 32'h0);

      fd = $fopen(INPUT_FILE, "r");
      if (fd == 0) begin
         n_errors++;
         $display("cannot open the stimulus file %s", INPUT_FILE);
         close_run();
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               n_fields = $sscanf(line, "%h %h %h %h %h %h %h", f_we, f_addr, f_wdata,
                                  f_strb, f_rdata, f_err, f_b2b);
               if (n_fields != 7) begin
                  n_errors++;
                  $display("stimulus line does not have seven fields: %s", line);
               end else begin
                  gaps = f_b2b[0] ? 0 : int'($urandom % 3);   // idle cycles before
                  repeat (gaps) drive_idle();
                  drive_access(f_we[0], f_addr, f_wdata, f_strb[3:0], f_rdata, f_err[0]);
               end
            end
         end
         $fclose(fd);
         drive_idle();

         wait_cycles = 0;
         while (exp_q.size() > 0 && wait_cycles < DRAIN_CYCLES) begin
            @(negedge ram_clk);
            wait_cycles++;
         end
         if (exp_q.size() > 0) begin
            n_errors++;
            $display("%0d responses still missing after the last access", exp_q.size());
         end

         check_value("host_exit_o", 32'(host_exit_o), 32'(tohost_model[0]));
         check_value("host_code_o", 32'(host_code_o), 32'(tohost_model[31:1]));
         close_run();
      end
   end

   initial begin
      #WATCHDOG_NS;
      n_errors++;
      $display("watchdog expired before the access sequence finished");
      close_run();
   end

endmodule

// ==== sim/io_top_props.sv ====
// response timing, device exclusivity and error flag checks for the IO decoder

`timescale 1ns/1ps

module io_top_props import io_pkg::*; (
   input logic ram_clk,
   input logic arst_n_i,
   input logic req_i,
   input logic host_req_o,
   input logic bram_req_o,
   input logic rsp_valid_o,
   input logic err_o
);

   // one response per request, exactly a cycle later
   a_rsp_after_req: assert property (
      @(posedge ram_clk) disable iff (!arst_n_i) req_i |=> rsp_valid_o
   ) else $error("request without a response in the next cycle");

   a_no_stray_rsp: assert property (
      @(posedge ram_clk) disable iff (!arst_n_i) !req_i |=> !rsp_valid_o
   ) else $error("response without a request in the cycle before");

   a_one_device: assert property (
      @(posedge ram_clk) disable iff (!arst_n_i) !(host_req_o && bram_req_o)
   ) else $error("host and RAM requested in the same cycle");

   a_err_in_rsp: assert property (
      @(posedge ram_clk) disable iff (!arst_n_i) err_o |-> rsp_valid_o
   ) else $error("error flag outside a response cycle");

endmodule

bind io_decoder io_top_props i_props (
   .ram_clk     ( ram_clk     ),
   .arst_n_i    ( arst_n_i    ),
   .req_i       ( req_i       ),
   .host_req_o  ( host_req_o  ),
   .bram_req_o  ( bram_req_o  ),
   .rsp_valid_o ( rsp_valid_o ),
   .err_o       ( err_o       )
);

// ==== hdl/io_top.sv ====
// on-chip IO region top, decoder with boot RAM path and host registers

`timescale 1ns/1ps

module io_top import io_pkg::*; (
   input  logic        ram_clk,
   input  logic        arst_n_i,
   input  logic        req_i,
   input  logic        we_i,
   input  io_addr_t    addr_i,
   input  io_data_t    wdata_i,
   input  io_strb_t    strb_i,
   output logic        rsp_valid_o,
   output io_data_t    rdata_o,
   output logic        err_o,
   output logic        host_exit_o,
   output logic [30:0] host_code_o
);

   logic            host_req;
   logic            bram_req;
   io_data_t        host_rdata;
   io_data_t        bram_rdata;

   logic            bram_en;
   bram_blk_t       bram_blk;
   bram_line_strb_t bram_line_strb;
   bram_line_t      bram_line_wdata;
   bram_line_t      bram_line_rdata;

   //////////////////////////////////////////////////
   // address decode and response

   io_decoder i_decoder (
      .ram_clk      ( ram_clk     ),
      .arst_n_i     ( arst_n_i    ),
      .req_i        ( req_i       ),
      .addr_i       ( addr_i      ),
      .host_rdata_i ( host_rdata  ),
      .bram_rdata_i ( bram_rdata  ),
      .host_req_o   ( host_req    ),
      .bram_req_o   ( bram_req    ),
      .rsp_valid_o  ( rsp_valid_o ),
      .rdata_o      ( rdata_o     ),
      .err_o        ( err_o       )
   );

   //////////////////////////////////////////////////
   // boot block RAM

   bram_lane_ctrl i_bram_lane_ctrl (
      .ram_clk      ( ram_clk         ),
      .arst_n_i     ( arst_n_i        ),
      .req_i        ( bram_req        ),
      .we_i         ( we_i            ),
      .addr_i       ( addr_i          ),
      .wdata_i      ( wdata_i         ),
      .strb_i       ( strb_i          ),
      .line_rdata_i ( bram_line_rdata ),
      .en_o         ( bram_en         ),
      .blk_o        ( bram_blk        ),
      .line_strb_o  ( bram_line_strb  ),
      .line_wdata_o ( bram_line_wdata ),
      .rdata_o      ( bram_rdata      )
   );

   bram_array i_bram_array (
      .ram_clk      ( ram_clk         ),
      .en_i         ( bram_en         ),
      .blk_i        ( bram_blk        ),
      .line_strb_i  ( bram_line_strb  ),
      .line_wdata_i ( bram_line_wdata ),
      .line_rdata_o ( bram_line_rdata )
   );

   //////////////////////////////////////////////////
   // host register pair for ISA regression

   host_regs i_host_regs (
      .ram_clk      ( ram_clk     ),
      .arst_n_i     ( arst_n_i    ),
      .req_i        ( host_req    ),
      .we_i         ( we_i        ),
      .addr_i       ( addr_i      ),
      .wdata_i      ( wdata_i     ),
      .strb_i       ( strb_i      ),
      .rdata_o      ( host_rdata  ),
      .host_exit_o  ( host_exit_o ),
      .host_code_o  ( host_code_o )
   );

endmodule

// ==== hdl/host_regs.sv ====
// tohost and fromhost registers with test exit level and exit code

`timescale 1ns/1ps

module host_regs import io_pkg::*; (
   input  logic        ram_clk,
   input  logic        arst_n_i,
   input  logic        req_i,
   input  logic        we_i,
   input  io_addr_t    addr_i,
   input  io_data_t    wdata_i,
   input  io_strb_t    strb_i,
   output io_data_t    rdata_o,
   output logic        host_exit_o,
   output logic [30:0] host_code_o
);

   io_data_t tohost_q;
   io_data_t fromhost_q;
   io_data_t rdata_q;
   logic     tohost_sel;
   logic     fromhost_sel;

   // strobed byte merge into an existing word
   function automatic io_data_t merge_bytes(io_data_t old_val, io_data_t new_val,
                                            io_strb_t strb);
      io_data_t res;
      res = old_val;
      for (int i = 0; i < IO_STRB_WIDTH; i++) begin
         if (strb[i]) begin
            res[i*8 +: 8] = new_val[i*8 +: 8];
         end
      end
      return res;
   endfunction

   assign tohost_sel   = addr_i[2] == HOST_TOHOST_OFS[2];
   assign fromhost_sel = addr_i[2] == HOST_FROMHOST_OFS[2];

   always_ff @(posedge ram_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tohost_q   <= '0;
         fromhost_q <= '0;
      end else if (req_i && we_i) begin
         if (tohost_sel) begin
            tohost_q <= merge_bytes(tohost_q, wdata_i, strb_i);
         end
         if (fromhost_sel) begin
            fromhost_q <= merge_bytes(fromhost_q, wdata_i, strb_i);
         end
      end
   end

   always_ff @(posedge ram_clk) begin
      if (req_i && !we_i) begin
         rdata_q <= fromhost_sel ? fromhost_q : tohost_q;
      end
   end

   assign rdata_o = rdata_q;

   // bit 0 ends the test, the rest is the exit code
   assign host_exit_o = tohost_q[0];
   assign host_code_o = tohost_q[IO_DATA_WIDTH-1:1];

endmodule

// ==== hdl/bram_array.sv ====
// byte writable boot RAM, one 128-bit line per index, registered read address

`timescale 1ns/1ps

module bram_array import io_pkg::*; (
   input  logic            ram_clk,
   input  logic            en_i,
   input  bram_blk_t       blk_i,
   input  bram_line_strb_t line_strb_i,
   input  bram_line_t      line_wdata_i,
   output bram_line_t      line_rdata_o
);

   bram_line_t mem [BRAM_LINES];
   bram_blk_t  blk_q;

   always_ff @(posedge ram_clk) begin
      if (en_i) begin
         blk_q <= blk_i;
         for (int i = 0; i < BRAM_WIDTH / 8; i++) begin
            if (line_strb_i[i]) begin
               mem[blk_i][i*8 +: 8] <= line_wdata_i[i*8 +: 8];
            end
         end
      end
   end

   // data of the line addressed on the last enable
   assign line_rdata_o = mem[blk_q];

endmodule

// ==== hdl/bram_lane_ctrl.sv ====
// word to line adapter for the boot RAM, lane placement and read lane select

`timescale 1ns/1ps

module bram_lane_ctrl import io_pkg::*; (
   input  logic            ram_clk,
   input  logic            arst_n_i,
   input  logic            req_i,
   input  logic            we_i,
   input  io_addr_t        addr_i,
   input  io_data_t        wdata_i,
   input  io_strb_t        strb_i,
   input  bram_line_t      line_rdata_i,
   output logic            en_o,
   output bram_blk_t       blk_o,
   output bram_line_strb_t line_strb_o,
   output bram_line_t      line_wdata_o,
   output io_data_t        rdata_o
);

   bram_lane_t lane;
   bram_lane_t lane_q;
   logic [BRAM_LANE_BITS+BRAM_OFFSET_BITS-1:0] strb_shift;

   // byte address splits into line, lane and byte offset
   assign blk_o = addr_i[BRAM_LANE_BITS+BRAM_OFFSET_BITS +: BRAM_BLK_BITS];
   assign lane  = addr_i[BRAM_OFFSET_BITS +: BRAM_LANE_BITS];

   assign en_o = req_i;

   //////////////////////////////////////////////////
   // write path

   // lane index in byte units
   assign strb_shift = {lane, {BRAM_OFFSET_BITS{1'b0}}};

   always_comb begin
      line_strb_o = '0;
      if (we_i) begin
         line_strb_o = bram_line_strb_t'(strb_i) << strb_shift;
      end
   end

   // same word in every lane, strobes pick the one that lands
   assign line_wdata_o = {BRAM_LANES{wdata_i}};

   //////////////////////////////////////////////////
   // read path

   always_ff @(posedge ram_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lane_q <= '0;
      end else if (req_i) begin
         lane_q <= lane;   // lines up with the registered line index
      end
   end

   assign rdata_o = line_rdata_i[lane_q*IO_DATA_WIDTH +: IO_DATA_WIDTH];

endmodule

// ==== hdl/io_decoder.sv ====
// IO region address decoder with device strobes and response mux

`timescale 1ns/1ps

module io_decoder import io_pkg::*; (
   input  logic     ram_clk,
   input  logic     arst_n_i,
   input  logic     req_i,
   input  io_addr_t addr_i,
   input  io_data_t host_rdata_i,
   input  io_data_t bram_rdata_i,
   output logic     host_req_o,
   output logic     bram_req_o,
   output logic     rsp_valid_o,
   output io_data_t rdata_o,
   output logic     err_o
);

   dev_sel_t dev_sel;     // device hit in the request cycle
   dev_sel_t dev_sel_q;   // device that answers this cycle
   logic     rsp_valid_q;
   logic     host_hit;
   logic     bram_hit;

   //////////////////////////////////////////////////
   // request side

   assign host_hit = (addr_i & HOST_MASK) == HOST_BASE;
   assign bram_hit = (addr_i & BRAM_MASK) == BRAM_BASE;

   always_comb begin
      dev_sel = dev_none;
      if (host_hit) begin
         dev_sel = dev_host;
      end else if (bram_hit) begin
         dev_sel = dev_bram;
      end
   end

   assign host_req_o = req_i && (dev_sel == dev_host);
   assign bram_req_o = req_i && (dev_sel == dev_bram);

   //////////////////////////////////////////////////
   // response side

   always_ff @(posedge ram_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rsp_valid_q <= 1'b0;
         dev_sel_q   <= dev_none;
      end else begin
         rsp_valid_q <= req_i;
         if (req_i) begin
            dev_sel_q <= dev_sel;   // held until the next request
         end
      end
   end

   always_comb begin
      case (dev_sel_q)
         dev_host: rdata_o = host_rdata_i;
         dev_bram: rdata_o = bram_rdata_i;
         default:  rdata_o = '0;
      endcase
   end

   assign rsp_valid_o = rsp_valid_q;
   assign err_o       = rsp_valid_q && (dev_sel_q == dev_none);   // unclaimed address

endmodule

// ==== hdl/io_pkg.sv ====
// bus widths, boot RAM geometry, device address map and shared IO types

package io_pkg;

   //////////////////////////////////////////////////
   // lite bus

   localparam int IO_ADDR_WIDTH = 32;
   localparam int IO_DATA_WIDTH = 32;
   localparam int IO_STRB_WIDTH = IO_DATA_WIDTH / 8;

   typedef logic [IO_ADDR_WIDTH-1:0] io_addr_t;
   typedef logic [IO_DATA_WIDTH-1:0] io_data_t;
   typedef logic [IO_STRB_WIDTH-1:0] io_strb_t;

   //////////////////////////////////////////////////
   // boot block RAM

   localparam int BRAM_SIZE_BITS   = 12;    // 4 KB
   localparam int BRAM_WIDTH       = 128;
   localparam int BRAM_LINES       = 2 ** BRAM_SIZE_BITS / (BRAM_WIDTH / 8);
   localparam int BRAM_OFFSET_BITS = 2;     // byte within word
   localparam int BRAM_LANE_BITS   = 2;     // word within line
   localparam int BRAM_LANES       = BRAM_WIDTH / IO_DATA_WIDTH;
   localparam int BRAM_BLK_BITS    = $clog2(BRAM_LINES);

   typedef logic [BRAM_WIDTH-1:0]     bram_line_t;
   typedef logic [BRAM_WIDTH/8-1:0]   bram_line_strb_t;
   typedef logic [BRAM_BLK_BITS-1:0]  bram_blk_t;
   typedef logic [BRAM_LANE_BITS-1:0] bram_lane_t;

   //////////////////////////////////////////////////
   // device map

   localparam io_addr_t HOST_BASE = 32'h4000_0000;
   localparam io_addr_t HOST_MASK = 32'hFFFF_FFF8;
   localparam io_addr_t BRAM_BASE = 32'h4001_0000;
   localparam io_addr_t BRAM_MASK = 32'hFFFF_F000;

   localparam io_addr_t HOST_TOHOST_OFS   = 32'h0;
   localparam io_addr_t HOST_FROMHOST_OFS = 32'h4;

   // device that owns the response in flight
   typedef enum logic [1:0] {
      dev_none,
      dev_host,
      dev_bram
   } dev_sel_t;

endpackage
